// ==== mcCore.f ====
hdl/rvPkg.sv
hdl/ctrlFsm.sv
hdl/instrDecode.sv
hdl/aluUnit.sv
hdl/regFile.sv
hdl/wordMem.sv
hdl/instrCounter.sv
hdl/execPath.sv
hdl/mcCore.sv
sim/clockGen.sv
sim/mcCore_properties.sv
sim/mcCoreTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the mcCore testbench with Verilator, result decided from sim.log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f mcCore.f --top-module mcCoreTb -o simv \
    && ./obj_dir/simv > sim.log 2>&1 \
    || echo "Errors found" >> sim.log
cat sim.log
grep -q "Errors found" sim.log && echo "FAIL" && exit 1 || echo "PASS"

// ==== sim/mcCoreTb.sv ====
module mcCoreTb;
    import rvPkg::*;

    logic               clk;
    logic               arstN;
    logic               run;
    logic               loadEn;
    logic [IMEM_AW-1:0] loadAddr;
    logic [XLEN-1:0]    loadData;
    logic [4:0]         dbgAddr;
    logic [XLEN-1:0]    dbgData;
    logic [XLEN-1:0]    cycleCount;
    logic [XLEN-1:0]    retiredCount;
    logic               halted;
    logic               fault;

    logic [31:0] prog[$];              // Program being built
    logic [31:0] modelRegs [32];
    logic [31:0] modelMem [DMEM_WORDS];
    logic [31:0] lfsr;
    string       testName;
    int          errorCount;
    int          testStartErrors;
    int          testsRun;
    int          cycleNow    = 0;
    int          cycleBudget = 200;    // Reset, reset test and margin

    clockGen i_clockGen (.clk(clk), .arstN(arstN));

    mcCore i_dut (
        .clk(clk), .arstN(arstN), .run(run), .loadEn(loadEn), .loadAddr(loadAddr),
        .loadData(loadData), .dbgAddr(dbgAddr), .dbgData(dbgData),
        .cycleCount(cycleCount), .retiredCount(retiredCount),
        .halted(halted), .fault(fault)
    );

    always @(posedge clk) begin
        cycleNow <= cycleNow + 1;
        if (cycleNow > cycleBudget) begin
            $display("Timeout after %0d cycles, the core never finished its program", cycleNow);
            $display("Errors found");
            $finish;
        end
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] randBits(int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic checkData(string what, logic [XLEN-1:0] expV, logic [XLEN-1:0] actV);
        if (actV !== expV) begin
            errorCount++;
            $display("Fail %s %s: expected %h, actual %h", testName, what, expV, actV);
        end
    endtask

    task automatic checkCount(string what, logic [31:0] expV, logic [31:0] actV);
        if (actV !== expV) begin
            errorCount++;
            $display("Fail %s %s: expected %0d, actual %0d", testName, what, expV, actV);
        end
    endtask

    task automatic checkFlag(string what, logic expV, logic actV);
        if (actV !== expV) begin
            errorCount++;
            $display("Fail %s %s: expected %b, actual %b", testName, what, expV, actV);
        end
    endtask

    task automatic emitReg(logic [6:0] f7, logic [2:0] f3, int rd, int rs1, int rs2);
        prog.push_back({f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011});
    endtask

    task automatic emitImm(logic [2:0] f3, int rd, int rs1, int imm);
        prog.push_back({12'(imm), 5'(rs1), f3, 5'(rd), 7'b0010011});
    endtask

    task automatic emitLoad(int rd, int rs1, int imm);
        prog.push_back({12'(imm), 5'(rs1), 3'b010, 5'(rd), 7'b0000011});
    endtask

    task automatic emitStore(int rs2, int rs1, int imm);
        logic [11:0] im;
        im = 12'(imm);
        prog.push_back({im[11:5], 5'(rs2), 5'(rs1), 3'b010, im[4:0], 7'b0100011});
    endtask

    task automatic emitBranch(logic [2:0] f3, int rs1, int rs2, int off);
        logic [12:0] o;
        o = 13'(off);
        prog.push_back({o[12], o[10:5], 5'(rs2), 5'(rs1), f3, o[4:1], o[11], 7'b1100011});
    endtask

    task automatic emitEcall();
        prog.push_back(32'h0000_0073);
    endtask

    // Full 32-bit value from ADDI, SLLI and ORI
    task automatic emitConst(int rd, logic [31:0] v);
        emitImm(3'd0, rd, 0, int'(v[31:21]));
        emitImm(3'd1, rd, rd, 11);
        emitImm(3'd6, rd, rd, int'(v[20:10]));
        emitImm(3'd1, rd, rd, 10);
        emitImm(3'd6, rd, rd, int'(v[9:0]));
    endtask

    // RV32I arithmetic by funct3 where alt picks SUB or SRA
    function automatic logic [31:0] aluRef(logic [2:0] f3, logic alt, logic [31:0] a,
                                           logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'd0, $signed(a) < $signed(b)};
            3'd3: return {31'd0, a < b};
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // Instruction-set model that also totals the per-class cycle cost
    task automatic runModel(output int cycles, output int retired, output logic faulted);
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] addr;
        logic [31:0] pcM;
        logic        taken;
        logic        done;
        cycles  = 0;
        retired = 0;
        faulted = 1'b0;
        pcM     = '0;
        done    = 1'b0;
        while (!done) begin
            w     = prog[pcM >> 2];
            a     = modelRegs[w[19:15]];
            b     = modelRegs[w[24:20]];
            res   = '0;
            taken = 1'b0;
            case (w[6:0])
                7'b0110011: begin
                    res     = aluRef(w[14:12], w[30], a, b);
                    cycles += 4;
                end
                7'b0010011: begin
                    res     = aluRef(w[14:12], w[14:12] == 3'd5 && w[30], a,
                                     {{20{w[31]}}, w[31:20]});
                    cycles += 4;
                end
                7'b0000011: begin
                    addr    = a + {{20{w[31]}}, w[31:20]};
                    res     = modelMem[addr[DMEM_AW+1:2]];
                    cycles += 5;
                end
                7'b0100011: begin
                    addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
                    modelMem[addr[DMEM_AW+1:2]] = b;
                    cycles += 4;
                end
                7'b1100011: begin
                    taken   = w[12] ? (a != b) : (a == b);
                    cycles += 3;
                end
                default: begin
                    cycles += 3;
                    faulted = (w != 32'h0000_0073);  // Anything but ECALL faults
                    done    = 1'b1;
                end
            endcase
            if (w[6:0] inside {7'b0110011, 7'b0010011, 7'b0000011} && w[11:7] != 5'd0) begin
                modelRegs[w[11:7]] = res;
            end
            if (!faulted) begin
                retired++;
            end
            if (taken) begin
                pcM = pcM + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            end else begin
                pcM = pcM + 32'd4;
            end
        end
    endtask

    task automatic readReg(int r, output logic [31:0] v);
        @(negedge clk);
        dbgAddr = 5'(r);
        @(negedge clk);
        v = dbgData;
    endtask

    task automatic checkRegs();
        logic [31:0] v;
        for (int r = 0; r < 32; r++) begin
            readReg(r, v);
            checkData($sformatf("x%0d", r), modelRegs[r], v);
        end
    endtask

    task automatic startTest(string name);
        testName        = name;
        testStartErrors = errorCount;
        testsRun++;
        prog.delete();
    endtask

    task automatic endTest();
        $display("Test %s: %s", testName, errorCount == testStartErrors ? "ok" : "FAILED");
    endtask

    // Load, run to halt, check everything, then drop run
    task automatic runProgram();
        int   expCycles;
        int   expRetired;
        logic expFault;
        runModel(expCycles, expRetired, expFault);
        cycleBudget += expCycles + 5 * prog.size() + 64;
        foreach (prog[i]) begin
            @(negedge clk);
            loadEn   = 1'b1;
            loadAddr = IMEM_AW'(i);
            loadData = prog[i];
        end
        @(negedge clk);
        loadEn = 1'b0;
        run    = 1'b1;
        while (!halted) begin
            @(negedge clk);
        end
        checkFlag("fault", expFault, fault);
        checkCount("cycles", 32'(expCycles), cycleCount);
        checkCount("retired", 32'(expRetired), retiredCount);
        checkRegs();
        @(negedge clk);
        run = 1'b0;
        @(negedge clk);
        checkFlag("halted after run low", 1'b0, halted);
        checkFlag("fault after run low", 1'b0, fault);
    endtask

    task automatic testReset();
        startTest("reset");
        @(negedge clk);
        checkFlag("halted", 1'b0, halted);
        checkFlag("fault", 1'b0, fault);
        checkCount("cycles", 32'd0, cycleCount);
        checkCount("retired", 32'd0, retiredCount);
        checkRegs();
        endTest();
    endtask

    task automatic testRegOps();
        startTest("register ops");
        emitConst(1, randBits(32));
        emitConst(2, randBits(32));
        emitConst(3, randBits(5));  // Shift amount
        emitReg(7'h00, 3'd0, 10, 1, 2);
        emitReg(7'h20, 3'd0, 11, 1, 2);
        emitReg(7'h00, 3'd7, 12, 1, 2);
        emitReg(7'h00, 3'd6, 13, 1, 2);
        emitReg(7'h00, 3'd4, 14, 1, 2);
        emitReg(7'h00, 3'd2, 15, 1, 2);
        emitReg(7'h00, 3'd3, 16, 2, 1);
        emitReg(7'h00, 3'd1, 17, 1, 3);
        emitReg(7'h00, 3'd5, 18, 1, 3);
        emitReg(7'h20, 3'd5, 19, 1, 3);
        emitEcall();
        runProgram();
        endTest();
    endtask

    task automatic testImmOps();
        int sh;
        startTest("immediate ops");
        sh = int'(randBits(5));
        emitConst(1, randBits(32) | 32'h8000_0000);  // Negative source for SRAI
        emitImm(3'd0, 5, 1, -5);
        emitImm(3'd0, 6, 0, int'(randBits(11)) | 12'h800);
        emitImm(3'd7, 7, 1, 12'hF0F);
        emitImm(3'd6, 8, 1, 12'h0A5);
        emitImm(3'd4, 9, 1, 12'h800);
        emitImm(3'd2, 10, 1, 1);
        emitImm(3'd3, 11, 1, 12'hFFF);
        emitImm(3'd3, 12, 0, 1);
        emitImm(3'd1, 13, 1, sh);
        emitImm(3'd5, 14, 1, sh);
        emitImm(3'd5, 15, 1, 12'h400 | sh);
        emitEcall();
        runProgram();
        endTest();
    endtask

    task automatic testMemOps();
        startTest("load store");
        emitImm(3'd0, 1, 0, 64);  // Base address
        emitConst(2, randBits(32));
        emitConst(3, randBits(32));
        emitConst(4, randBits(32));
        emitStore(2, 1, 0);
        emitStore(3, 1, 60);
        emitStore(4, 1, -8);
        emitLoad(20, 1, 0);
        emitLoad(21, 1, 60);
        emitLoad(22, 1, -8);
        emitLoad(0, 1, 60);
        emitImm(3'd0, 0, 2, 0);
        emitEcall();
        runProgram();
        endTest();
    endtask

    task automatic testBranchLoop();
        int          n;
        logic [31:0] v;
        startTest("branch loop");
        n = 3 + int'(randBits(3));
        emitImm(3'd0, 1, 0, n);
        emitImm(3'd0, 2, 0, 0);
        emitImm(3'd0, 2, 2, 1);      // Loop body starts at word 2
        emitImm(3'd0, 1, 1, -1);
        emitBranch(3'd1, 1, 0, -8);
        emitBranch(3'd0, 1, 2, 8);   // Not taken
        emitBranch(3'd0, 0, 0, 8);   // Taken so the next word is skipped
        emitImm(3'd0, 3, 0, 99);
        emitEcall();
        runProgram();
        readReg(2, v);
        checkData("iterations", 32'(n), v);
        endTest();
    endtask

    task automatic testIllegal();
        startTest("illegal");
        emitImm(3'd0, 6, 0, 7);
        emitImm(3'd0, 7, 6, 1);
        prog.push_back(32'hFFFF_FFFF);
        emitImm(3'd0, 8, 0, 1);
        emitEcall();
        runProgram();
        endTest();
        startTest("restart");
        emitImm(3'd0, 9, 0, 33);
        emitImm(3'd0, 8, 9, 2);
        emitEcall();
        runProgram();
        endTest();
    endtask

    initial begin
        run        = 1'b0;
        loadEn     = 1'b0;
        loadAddr   = '0;
        loadData   = '0;
        dbgAddr    = '0;
        lfsr       = 32'h66a72785;
        errorCount = 0;
        testsRun   = 0;
        foreach (modelRegs[i]) begin
            modelRegs[i] = '0;
        end
        foreach (modelMem[i]) begin
            modelMem[i] = '0;
        end
        @(posedge arstN);
        testReset();
        testRegOps();
        testImmOps();
        testMemOps();
        testBranchLoop();
        testIllegal();
        $display("Tests run: %0d, errors: %0d", testsRun, errorCount);
        if (errorCount == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== sim/mcCore_properties.sv ====
module mcCore_properties (
    input logic         clk,
    input logic         arstN,
    input logic         run,
    input rvPkg::stateE state,
    input rvPkg::stepT  step,
    input logic         halted,
    input logic [31:0]  x0
);
    import rvPkg::*;

    parkedQuiet: assert property (@(posedge clk) disable iff (!arstN)
        (state == IDLE || state == HALT) |-> step == '0)
        else $error("step enables active while idle or halted");

    haltHeld: assert property (@(posedge clk) disable iff (!arstN)
        halted && run |=> halted)
        else $error("halted dropped while run was still high");

    // Writes aimed at x0 must leave it at zero
    x0Stays: assert property (@(posedge clk) disable iff (!arstN)
        x0 == '0)
        else $error("register x0 holds a nonzero value");

endmodule

// FSM view, the register side is tied off
bind ctrlFsm mcCore_properties i_fsmProps (
    .clk(clk), .arstN(arstN), .run(run), .state(state), .step(step),
    .halted(halted), .x0(32'd0)
);

// Register file view, the FSM side is tied off
bind regFile mcCore_properties i_rfProps (
    .clk(clk), .arstN(arstN), .run(1'b0), .state(rvPkg::IDLE),
    .step(rvPkg::stepT'('0)), .halted(1'b0), .x0(regs[0])
);

// ==== sim/clockGen.sv ====
module clockGen (
    output logic clk,
    output logic arstN
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // Period of 40
    end

    initial begin
        arstN = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;  // Release away from the active edge
    end

endmodule

// ==== hdl/mcCore.sv ====
module mcCore (
    input  logic                      clk,
    input  logic                      arstN,
    input  logic                      run,
    input  logic                      loadEn,
    input  logic [rvPkg::IMEM_AW-1:0] loadAddr,
    input  logic [31:0]               loadData,
    input  logic [4:0]                dbgAddr,
    output logic [31:0]               dbgData,
    output logic [31:0]               cycleCount,
    output logic [31:0]               retiredCount,
    output logic                      halted,
    output logic                      fault
);
    import rvPkg::*;

    decodedT           dec;
    stepT              step;
    logic              zero;
    logic              dmemWe;
    logic              imemWe;
    logic              clear;
    logic              retire;
    logic              running;
    logic [31:0]       pc;
    logic [31:0]       instr;
    logic [31:0]       opA;
    logic [31:0]       opB;
    logic [31:0]       aluY;
    logic [31:0]       aluOut;
    logic [31:0]       wbData;
    logic [31:0]       storeData;
    logic [31:0]       rd1;
    logic [31:0]       rd2;
    logic [31:0]       imemData;
    logic [31:0]       dmemData;
    logic [IMEM_AW-1:0] imemAddr;

    assign imemAddr = imemWe ? loadAddr : pc[IMEM_AW+1:2];  // Loader owns the port when idle

    ctrlFsm u_ctrlFsm (
        .clk(clk), .arstN(arstN), .run(run), .loadEn(loadEn), .dec(dec), .zero(zero),
        .step(step), .dmemWe(dmemWe), .imemWe(imemWe), .clear(clear), .retire(retire),
        .running(running), .halted(halted), .fault(fault)
    );

    instrDecode u_instrDecode (.instr(instr), .dec(dec));

    aluUnit u_aluUnit (.a(opA), .b(opB), .op(dec.ctrl.aluOp), .y(aluY), .zero(zero));

    regFile u_regFile (
        .clk(clk), .arstN(arstN), .rs1(dec.rs1), .rs2(dec.rs2), .rd(dec.rd),
        .dbgAddr(dbgAddr), .we(step.rfWrite), .wd(wbData),
        .rd1(rd1), .rd2(rd2), .dbgData(dbgData)
    );

    wordMem #(.Depth(IMEM_WORDS)) u_imem (
        .clk(clk), .we(imemWe), .addr(imemAddr), .wdata(loadData), .rdata(imemData)
    );

    wordMem #(.Depth(DMEM_WORDS)) u_dmem (
        .clk(clk), .we(dmemWe), .addr(aluOut[DMEM_AW+1:2]), .wdata(storeData),
        .rdata(dmemData)
    );

    instrCounter u_instrCounter (
        .clk(clk), .arstN(arstN), .clear(clear), .running(running), .retire(retire),
        .cycleCount(cycleCount), .retiredCount(retiredCount)
    );

    execPath u_execPath (
        .clk(clk), .arstN(arstN), .step(step), .clear(clear), .dec(dec),
        .imemData(imemData), .rd1(rd1), .rd2(rd2), .aluY(aluY), .dmemData(dmemData),
        .pc(pc), .instr(instr), .opA(opA), .opB(opB), .aluOut(aluOut),
        .wbData(wbData), .storeData(storeData)
    );

endmodule

// ==== hdl/execPath.sv ====
module execPath (
    input  logic           clk,
    input  logic           arstN,
    input  rvPkg::stepT    step,
    input  logic           clear,
    input  rvPkg::decodedT dec,
    input  logic [31:0]    imemData,
    input  logic [31:0]    rd1,
    input  logic [31:0]    rd2,
    input  logic [31:0]    aluY,
    input  logic [31:0]    dmemData,
    output logic [31:0]    pc,
    output logic [31:0]    instr,
    output logic [31:0]    opA,
    output logic [31:0]    opB,
    output logic [31:0]    aluOut,
    output logic [31:0]    wbData,
    output logic [31:0]    storeData
);
    import rvPkg::*;

    logic [XLEN-1:0] rs2Val;  // Operand B as read from the register file
    logic [XLEN-1:0] mdr;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else if (clear) begin
            pc <= '0;
        end else if (step.pcBranch) begin
            pc <= pc + dec.imm;  // Taken branch
        end else if (step.pcInc) begin
            pc <= pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (step.irLoad) begin
            instr <= imemData;
        end
        if (step.opLoad) begin
            opA    <= rd1;
            rs2Val <= rd2;
        end
        if (step.aluLoad) begin
            aluOut <= aluY;
        end
        if (step.mdrLoad) begin
            mdr <= dmemData;
        end
    end

    assign opB       = dec.ctrl.aluSrcImm ? dec.imm : rs2Val;
    assign wbData    = dec.ctrl.memRead ? mdr : aluOut;
    assign storeData = rs2Val;

endmodule

// ==== hdl/instrCounter.sv ====
module instrCounter (
    input  logic        clk,
    input  logic        arstN,
    input  logic        clear,
    input  logic        running,
    input  logic        retire,
    output logic [31:0] cycleCount,
    output logic [31:0] retiredCount
);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            cycleCount   <= '0;
            retiredCount <= '0;
        end else if (clear) begin  // Start of a new run
            cycleCount   <= '0;
            retiredCount <= '0;
        end else begin
            cycleCount   <= cycleCount + {31'd0, running};
            retiredCount <= retiredCount + {31'd0, retire};
        end
    end

endmodule

// ==== hdl/wordMem.sv ====
module wordMem #(
    parameter int Depth = 64
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(Depth)-1:0] addr,
    input  logic [31:0]              wdata,
    output logic [31:0]              rdata
);

    logic [31:0] mem [Depth];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    assign rdata = mem[addr];  // Read is combinational

endmodule

// ==== hdl/regFile.sv ====
module regFile (
    input  logic        clk,
    input  logic        arstN,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic [4:0]  rd,
    input  logic [4:0]  dbgAddr,
    input  logic        we,
    input  logic [31:0] wd,
    output logic [31:0] rd1,
    output logic [31:0] rd2,
    output logic [31:0] dbgData
);

    logic [31:0] regs [32];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 5'd0) begin  // x0 stays zero
            regs[rd] <= wd;
        end
    end

    assign rd1     = regs[rs1];
    assign rd2     = regs[rs2];
    assign dbgData = regs[dbgAddr];

endmodule

// ==== hdl/aluUnit.sv ====
module aluUnit (
    input  logic [31:0]  a,
    input  logic [31:0]  b,
    input  rvPkg::aluOpE op,
    output logic [31:0]  y,
    output logic         zero
);
    import rvPkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ADD:  y = a + b;
            SUB:  y = a - b;
            AND:  y = a & b;
            OR:   y = a | b;
            XOR:  y = a ^ b;
            SLT:  y = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            SLTU: y = {{(XLEN-1){1'b0}}, a < b};
            SLL:  y = a << shamt;
            SRL:  y = a >> shamt;
            SRA:  y = $signed(a) >>> shamt;
            default: y = '0;
        endcase
    end

    assign zero = (y == '0);  // Equal operands on SUB

endmodule

// ==== hdl/instrDecode.sv ====
module instrDecode (
    input  logic [31:0]    instr,
    output rvPkg::decodedT dec
);
    import rvPkg::*;

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] immI;
    logic [31:0] immS;
    logic [31:0] immB;
    logic        altF7;  // funct7 selects SUB or SRA
    logic        zeroF7;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign altF7  = (funct7 == 7'b0100000);
    assign zeroF7 = (funct7 == 7'b0000000);

    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

    assign dec.rs1 = instr[19:15];
    assign dec.rs2 = instr[24:20];
    assign dec.rd  = instr[11:7];

    always_comb begin
        dec.ctrl         = '0;
        dec.ctrl.aluOp   = ADD;
        dec.ctrl.illegal = 1'b1;  // Cleared on a match
        dec.imm          = immI;
        case (opcode)
            OPC_REG: begin
                dec.ctrl.regWrite = 1'b1;
                dec.ctrl.illegal  = 1'b0;
                case (funct3)
                    3'b000: dec.ctrl.aluOp = altF7 ? SUB : ADD;
                    3'b001: dec.ctrl.aluOp = SLL;
                    3'b010: dec.ctrl.aluOp = SLT;
                    3'b011: dec.ctrl.aluOp = SLTU;
                    3'b100: dec.ctrl.aluOp = XOR;
                    3'b101: dec.ctrl.aluOp = altF7 ? SRA : SRL;
                    3'b110: dec.ctrl.aluOp = OR;
                    default: dec.ctrl.aluOp = AND;
                endcase
                if (!(zeroF7 || (altF7 && (funct3 == 3'b000 || funct3 == 3'b101)))) begin
                    dec.ctrl.illegal = 1'b1;
                end
            end
            OPC_IMM: begin
                dec.ctrl.regWrite  = 1'b1;
                dec.ctrl.aluSrcImm = 1'b1;
                dec.ctrl.illegal   = 1'b0;
                case (funct3)
                    3'b000: dec.ctrl.aluOp = ADD;
                    3'b001: dec.ctrl.aluOp = SLL;
                    3'b010: dec.ctrl.aluOp = SLT;
                    3'b011: dec.ctrl.aluOp = SLTU;
                    3'b100: dec.ctrl.aluOp = XOR;
                    3'b101: dec.ctrl.aluOp = altF7 ? SRA : SRL;
                    3'b110: dec.ctrl.aluOp = OR;
                    default: dec.ctrl.aluOp = AND;
                endcase
                if (funct3 == 3'b001 && !zeroF7) begin
                    dec.ctrl.illegal = 1'b1;
                end
                if (funct3 == 3'b101 && !(zeroF7 || altF7)) begin
                    dec.ctrl.illegal = 1'b1;
                end
            end
            OPC_LOAD: begin
                dec.ctrl.regWrite  = 1'b1;
                dec.ctrl.memRead   = 1'b1;
                dec.ctrl.aluSrcImm = 1'b1;
                dec.ctrl.illegal   = (funct3 != 3'b010);  // LW only
            end
            OPC_STORE: begin
                dec.ctrl.memWrite  = 1'b1;
                dec.ctrl.aluSrcImm = 1'b1;
                dec.ctrl.illegal   = (funct3 != 3'b010);  // SW only
                dec.imm            = immS;
            end
            OPC_BRANCH: begin
                dec.ctrl.branch   = 1'b1;
                dec.ctrl.branchNe = funct3[0];
                dec.ctrl.aluOp    = SUB;  // Compare by subtraction
                dec.ctrl.illegal  = (funct3[2:1] != 2'b00);
                dec.imm           = immB;
            end
            OPC_SYSTEM: begin
                dec.ctrl.halt    = (instr == ECALL_WORD);
                dec.ctrl.illegal = (instr != ECALL_WORD);
            end
            default: ;
        endcase
    end

endmodule

// ==== hdl/ctrlFsm.sv ====
module ctrlFsm (
    input  logic          clk,
    input  logic          arstN,
    input  logic          run,
    input  logic          loadEn,
    input  rvPkg::decodedT dec,
    input  logic          zero,
    output rvPkg::stepT   step,
    output logic          dmemWe,
    output logic          imemWe,
    output logic          clear,
    output logic          retire,
    output logic          running,
    output logic          halted,
    output logic          fault
);
    import rvPkg::*;

    stateE state;
    stateE nextState;
    logic  taken;

    assign taken   = zero ^ dec.ctrl.branchNe;  // BNE flips the compare
    assign running = (state != IDLE) && (state != HALT);
    assign imemWe  = loadEn && (state == IDLE);  // Loads only while idle

    always_comb begin
        nextState = state;
        step      = '0;
        dmemWe    = 1'b0;
        retire    = 1'b0;
        clear     = 1'b0;
        case (state)
            IDLE: begin
                if (run) begin
                    nextState = FETCH;
                    clear     = 1'b1;  // PC and counters restart
                end
            end
            FETCH: begin
                step.irLoad = 1'b1;
                nextState   = DECODE;
            end
            DECODE: begin
                step.opLoad = 1'b1;
                nextState   = EXEC;
            end
            EXEC: begin
                if (dec.ctrl.illegal) begin
                    nextState = HALT;
                end else if (dec.ctrl.halt) begin
                    nextState = HALT;
                    retire    = 1'b1;  // ECALL retires
                end else if (dec.ctrl.branch) begin
                    step.pcBranch = taken;
                    step.pcInc    = ~taken;
                    retire        = 1'b1;
                    nextState     = FETCH;
                end else begin
                    step.aluLoad = 1'b1;
                    if (dec.ctrl.memRead || dec.ctrl.memWrite) begin
                        nextState = MEM;
                    end else begin
                        nextState = WB;
                    end
                end
            end
            MEM: begin
                if (dec.ctrl.memWrite) begin
                    dmemWe     = 1'b1;
                    step.pcInc = 1'b1;
                    retire     = 1'b1;
                    nextState  = FETCH;
                end else begin
                    step.mdrLoad = 1'b1;
                    nextState    = WB;
                end
            end
            WB: begin
                step.rfWrite = dec.ctrl.regWrite;
                step.pcInc   = 1'b1;
                retire       = 1'b1;
                nextState    = FETCH;
            end
            HALT: begin
                if (!run) begin
                    nextState = IDLE;
                end
            end
            default: nextState = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state  <= IDLE;
            halted <= 1'b0;
            fault  <= 1'b0;
        end else begin
            state <= nextState;
            if (state == EXEC && nextState == HALT) begin
                halted <= 1'b1;
                fault  <= dec.ctrl.illegal;
            end else if (nextState == IDLE) begin
                halted <= 1'b0;
                fault  <= 1'b0;
            end
        end
    end

endmodule

// ==== hdl/rvPkg.sv ====
package rvPkg;

    localparam int XLEN       = 32;
    localparam int IMEM_WORDS = 64;
    localparam int DMEM_WORDS = 64;
    localparam int IMEM_AW    = $clog2(IMEM_WORDS);
    localparam int DMEM_AW    = $clog2(DMEM_WORDS);

    // RV32I major opcodes handled by the decoder
    localparam logic [6:0] OPC_REG    = 7'b0110011;
    localparam logic [6:0] OPC_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    localparam logic [31:0] ECALL_WORD = 32'h0000_0073;

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        DECODE,
        EXEC,
        MEM,
        WB,
        HALT
    } stateE;

    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR, SLT, SLTU, SLL, SRL, SRA
    } aluOpE;

    typedef struct packed {
        aluOpE aluOp;
        logic  aluSrcImm;  // Operand B from immediate
        logic  regWrite;
        logic  memRead;
        logic  memWrite;
        logic  branch;
        logic  branchNe;   // Invert branch sense
        logic  halt;
        logic  illegal;
    } ctrlT;

    typedef struct packed {
        ctrlT        ctrl;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [31:0] imm;  // Already sign extended
    } decodedT;

    typedef struct packed {
        logic irLoad;
        logic opLoad;
        logic aluLoad;
        logic pcInc;
        logic pcBranch;
        logic mdrLoad;
        logic rfWrite;
    } stepT;

endpackage
